/* source/wb_params.svh */
////////////////////////////////////////
// Writeback parameters
// Widths and sizes shared by the writeback datapath.
////////////////////////////////////////
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

// width of one datapath word.
`define WB_DATA_W 32

// number of general purpose registers.
`define WB_REG_NUM 32

// bits needed to address one general register.
`define WB_REG_AW 5

// JAL and JALR write back the address two instructions past the jump,
// which skips the delay slot.
`define WB_PC_INC 8

`endif

/* source/wbPkg.sv */
////////////////////////////////////////
// Writeback package
// Types shared by the writeback stage and its top level.
////////////////////////////////////////
`default_nettype none

package wbPkg;

    // source of the word written back into the register file.
    typedef enum logic [1:0] {
        WB_SEL_LINK = 2'd0, // return address for link instructions.
        WB_SEL_ALU  = 2'd1, // result computed by the ALU.
        WB_SEL_OPB  = 2'd2, // B operand, used by MTHI and MTLO style moves.
        WB_SEL_MEM  = 2'd3  // data returned by a load.
    } WbSelType;

endpackage

`default_nettype wire

/* source/wbStage.sv */
////////////////////////////////////////
// wbStage
// MEM2-to-WB pipeline register, result select
// and write suppression during a data cache stall.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module wbStage
    import wbPkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    wbFlush,
    input  wire logic                    wbWr,
    input  wire logic                    wbDisWr,

    input  wire logic [`WB_DATA_W-1:0]   mem2AluOut,
    input  wire logic [`WB_DATA_W-1:0]   mem2Pc,
    input  wire logic [`WB_DATA_W-1:0]   mem2Instr,
    input  wire logic [`WB_DATA_W-1:0]   mem2OutB,
    input  wire logic [`WB_DATA_W-1:0]   mem2DmOut,
    input  wire WbSelType                mem2WbSel,
    input  wire logic [`WB_REG_AW-1:0]   mem2Dst,
    input  wire logic                    mem2GprWr,
    input  wire logic                    mem2HiWr,
    input  wire logic                    mem2LoWr,
    input  wire logic                    mem2StoreReq,

    output logic      [`WB_DATA_W-1:0]   wbResult,
    output logic      [`WB_DATA_W-1:0]   wbPc,
    output logic      [`WB_DATA_W-1:0]   wbAluOut,
    output logic      [`WB_DATA_W-1:0]   wbOutB,
    output logic      [`WB_REG_AW-1:0]   wbDst,
    output logic                         finalGprWr,
    output logic                         finalHiWr,
    output logic                         finalLoWr,
    output logic                         wbStoreReq
);

    localparam logic [`WB_DATA_W-1:0] LinkOffset = `WB_PC_INC;

    logic [`WB_DATA_W-1:0] wbDmOut;   // loaded data held by the stage.
    WbSelType              wbSel;     // stored result select.
    logic                  wbGprWr;   // stored general register write type.
    logic                  wbHiWr;    // stored HI write type.
    logic                  wbLoWr;    // stored LO write type.

    // Flush wins over the write enable, so a flushed item never lands even
    // while the pipeline is advancing.
    always_ff @(posedge clk) begin
        if (rst || wbFlush) begin
            wbAluOut   <= '0;
            wbPc       <= '0;
            wbOutB     <= '0;
            wbDmOut    <= '0;
            wbSel      <= WB_SEL_LINK;
            wbDst      <= '0;
            wbGprWr    <= 1'b0;
            wbHiWr     <= 1'b0;
            wbLoWr     <= 1'b0;
            wbStoreReq <= 1'b0;
        end else if (wbWr) begin
            wbAluOut   <= mem2AluOut;
            wbPc       <= mem2Pc;
            wbOutB     <= mem2OutB;
            wbDmOut    <= mem2DmOut;
            wbSel      <= mem2WbSel;
            wbDst      <= mem2Dst;
            wbGprWr    <= mem2GprWr;
            wbHiWr     <= mem2HiWr;
            wbLoWr     <= mem2LoWr;
            wbStoreReq <= mem2StoreReq; // passes through untouched.
        end
    end

    always_comb begin
        case (wbSel)
            WB_SEL_LINK: wbResult = wbPc + LinkOffset; // return address of JAL and JALR.
            WB_SEL_ALU:  wbResult = wbAluOut;
            WB_SEL_OPB:  wbResult = wbOutB;             // moves to HI, LO and the CP0 path.
            WB_SEL_MEM:  wbResult = wbDmOut;
            default:     wbResult = wbAluOut;
        endcase
    end

    // A data cache stall freezes the pipeline around this stage, so the held
    // item must not touch the register file until the stall is released.
    assign finalGprWr = wbDisWr ? 1'b0 : wbGprWr;
    assign finalHiWr  = wbDisWr ? 1'b0 : wbHiWr;
    assign finalLoWr  = wbDisWr ? 1'b0 : wbLoWr;

endmodule

`default_nettype wire

/* source/archState.sv */
////////////////////////////////////////
// archState
// General register file with the HI and LO registers.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module archState (
    input  wire logic                    clk,
    input  wire logic                    rst,

    input  wire logic                    gprWr,
    input  wire logic                    hiWr,
    input  wire logic                    loWr,
    input  wire logic [`WB_REG_AW-1:0]   wrAddr,
    input  wire logic [`WB_DATA_W-1:0]   wrData,
    input  wire logic [`WB_DATA_W-1:0]   hiLoData,

    input  wire logic [`WB_REG_AW-1:0]   rdAddrA,
    input  wire logic [`WB_REG_AW-1:0]   rdAddrB,
    output logic      [`WB_DATA_W-1:0]   rdDataA,
    output logic      [`WB_DATA_W-1:0]   rdDataB,
    output logic      [`WB_DATA_W-1:0]   hiData,
    output logic      [`WB_DATA_W-1:0]   loData
);

    logic [`WB_DATA_W-1:0] gprFile [`WB_REG_NUM]; // general purpose registers.
    logic [`WB_DATA_W-1:0] hiReg;                 // upper half of mult and div results.
    logic [`WB_DATA_W-1:0] loReg;                 // lower half of mult and div results.

    logic                  gprWrEn;               // write enable with register 0 excluded.

    assign gprWrEn = gprWr && (wrAddr != '0); // register 0 is hardwired to zero.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `WB_REG_NUM; i++) begin
                gprFile[i] <= '0;
            end
        end else if (gprWrEn) begin
            gprFile[wrAddr] <= wrData;
        end
    end

    // HI and LO both take the B operand, matching MTHI and MTLO.
    always_ff @(posedge clk) begin
        if (rst) begin
            hiReg <= '0;
            loReg <= '0;
        end else begin
            if (hiWr) begin
                hiReg <= hiLoData;
            end
            if (loWr) begin
                loReg <= hiLoData;
            end
        end
    end

    // reads are combinational, so a write is visible right after its edge.
    assign rdDataA = (rdAddrA == '0) ? '0 : gprFile[rdAddrA];
    assign rdDataB = (rdAddrB == '0) ? '0 : gprFile[rdAddrB];

    assign hiData  = hiReg;
    assign loData  = loReg;

endmodule

`default_nettype wire

/* source/writebackTop.sv */
////////////////////////////////////////
// writebackTop
// Writeback stage joined to the architectural state.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module writebackTop
    import wbPkg::*;
(
    input  wire logic                    clk,
    input  wire logic                    rst,
    input  wire logic                    wbFlush,
    input  wire logic                    wbWr,
    input  wire logic                    wbDisWr,

    input  wire logic [`WB_DATA_W-1:0]   mem2AluOut,
    input  wire logic [`WB_DATA_W-1:0]   mem2Pc,
    input  wire logic [`WB_DATA_W-1:0]   mem2Instr,
    input  wire logic [`WB_DATA_W-1:0]   mem2OutB,
    input  wire logic [`WB_DATA_W-1:0]   mem2DmOut,
    input  wire WbSelType                mem2WbSel,
    input  wire logic [`WB_REG_AW-1:0]   mem2Dst,
    input  wire logic                    mem2GprWr,
    input  wire logic                    mem2HiWr,
    input  wire logic                    mem2LoWr,
    input  wire logic                    mem2StoreReq,

    input  wire logic [`WB_REG_AW-1:0]   rdAddrA,
    input  wire logic [`WB_REG_AW-1:0]   rdAddrB,

    output logic      [`WB_DATA_W-1:0]   wbResult,
    output logic      [`WB_REG_AW-1:0]   wbDst,
    output logic      [`WB_DATA_W-1:0]   wbPc,
    output logic      [`WB_DATA_W-1:0]   wbAluOut,
    output logic                         wbStoreReq,
    output logic      [`WB_DATA_W-1:0]   rdDataA,
    output logic      [`WB_DATA_W-1:0]   rdDataB,
    output logic      [`WB_DATA_W-1:0]   hiData,
    output logic      [`WB_DATA_W-1:0]   loData
);

    logic [`WB_DATA_W-1:0] wbOutB;      // B operand, feeds HI and LO.
    logic                  finalGprWr;  // write types after stall suppression.
    logic                  finalHiWr;
    logic                  finalLoWr;

    wbStage uStage (
        .clk          (clk),
        .rst          (rst),
        .wbFlush      (wbFlush),
        .wbWr         (wbWr),
        .wbDisWr      (wbDisWr),
        .mem2AluOut   (mem2AluOut),
        .mem2Pc       (mem2Pc),
        .mem2Instr    (mem2Instr),
        .mem2OutB     (mem2OutB),
        .mem2DmOut    (mem2DmOut),
        .mem2WbSel    (mem2WbSel),
        .mem2Dst      (mem2Dst),
        .mem2GprWr    (mem2GprWr),
        .mem2HiWr     (mem2HiWr),
        .mem2LoWr     (mem2LoWr),
        .mem2StoreReq (mem2StoreReq),
        .wbResult     (wbResult),
        .wbPc         (wbPc),
        .wbAluOut     (wbAluOut),
        .wbOutB       (wbOutB),
        .wbDst        (wbDst),
        .finalGprWr   (finalGprWr),
        .finalHiWr    (finalHiWr),
        .finalLoWr    (finalLoWr),
        .wbStoreReq   (wbStoreReq)
    );

    archState uArch (
        .clk      (clk),
        .rst      (rst),
        .gprWr    (finalGprWr),
        .hiWr     (finalHiWr),
        .loWr     (finalLoWr),
        .wrAddr   (wbDst),
        .wrData   (wbResult),
        .hiLoData (wbOutB),
        .rdAddrA  (rdAddrA),
        .rdAddrB  (rdAddrB),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .hiData   (hiData),
        .loData   (loData)
    );

endmodule

`default_nettype wire

/* dv/writebackTb.sv */
////////////////////////////////////////
// writebackTb
// Drives the writeback top level and checks it
// against a cycle model of the stage and state.
////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

`include "wb_params.svh"

module writebackTb
    import wbPkg::*;
();

    localparam int ResetCycles    = 2;
    localparam int SelectCycles   = 12;  // four selects, three rounds.
    localparam int GprCycles      = 24;
    localparam int HiLoCycles     = 12;
    localparam int StallCycles    = 12;  // two rounds of load plus five held cycles.
    localparam int FlushCycles    = 4;
    localparam int SuppressCycles = 12;  // two rounds of load, three blocked, two released.
    localparam int RandomCycles   = 200;
    localparam int CycleLimit     = ResetCycles + SelectCycles + GprCycles + HiLoCycles
                                  + StallCycles + FlushCycles + SuppressCycles
                                  + RandomCycles + 120;

    logic                    clk;
    logic                    rst;
    logic                    wbFlush;
    logic                    wbWr;
    logic                    wbDisWr;
    logic [`WB_DATA_W-1:0]   mem2AluOut;
    logic [`WB_DATA_W-1:0]   mem2Pc;
    logic [`WB_DATA_W-1:0]   mem2Instr;
    logic [`WB_DATA_W-1:0]   mem2OutB;
    logic [`WB_DATA_W-1:0]   mem2DmOut;
    WbSelType                mem2WbSel;
    logic [`WB_REG_AW-1:0]   mem2Dst;
    logic                    mem2GprWr;
    logic                    mem2HiWr;
    logic                    mem2LoWr;
    logic                    mem2StoreReq;
    logic [`WB_REG_AW-1:0]   rdAddrA;
    logic [`WB_REG_AW-1:0]   rdAddrB;
    logic [`WB_DATA_W-1:0]   wbResult;
    logic [`WB_REG_AW-1:0]   wbDst;
    logic [`WB_DATA_W-1:0]   wbPc;
    logic [`WB_DATA_W-1:0]   wbAluOut;
    logic                    wbStoreReq;
    logic [`WB_DATA_W-1:0]   rdDataA;
    logic [`WB_DATA_W-1:0]   rdDataB;
    logic [`WB_DATA_W-1:0]   hiData;
    logic [`WB_DATA_W-1:0]   loData;

    // cycle model of the stage contents and the architectural state.
    logic [`WB_DATA_W-1:0]   mAluOut;
    logic [`WB_DATA_W-1:0]   mPc;
    logic [`WB_DATA_W-1:0]   mOutB;
    logic [`WB_DATA_W-1:0]   mDmOut;
    WbSelType                mSel;
    logic [`WB_REG_AW-1:0]   mDst;
    logic                    mGprWr;
    logic                    mHiWr;
    logic                    mLoWr;
    logic                    mStoreReq;
    logic [`WB_DATA_W-1:0]   mGpr [`WB_REG_NUM];
    logic [`WB_DATA_W-1:0]   mHi;
    logic [`WB_DATA_W-1:0]   mLo;

    integer                  seed = 32'hd681;
    int                      cycleCount = 0;
    string                   testName = "reset";
    logic [`WB_REG_AW-1:0]   savedDst = '0;  // destination written at the coming edge.

    writebackTop DUT (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [`WB_DATA_W-1:0] randWord();
        return $random(seed);
    endfunction

    // word the stage should write back, per the select rules.
    function automatic logic [`WB_DATA_W-1:0] expectedResult();
        case (mSel)
            WB_SEL_LINK: return mPc + `WB_PC_INC;
            WB_SEL_ALU:  return mAluOut;
            WB_SEL_OPB:  return mOutB;
            WB_SEL_MEM:  return mDmOut;
            default:     return mAluOut;
        endcase
    endfunction

    function automatic logic [`WB_DATA_W-1:0] expectedRead(input logic [`WB_REG_AW-1:0] addr);
        return (addr == '0) ? '0 : mGpr[addr];
    endfunction

    task automatic checkValue(input string what, input logic [`WB_DATA_W-1:0] expVal,
                              input logic [`WB_DATA_W-1:0] actVal);
        assert (actVal === expVal) else begin
            $display("[FAIL] %s %s: expected %h, actual %h", testName, what, expVal, actVal);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    always @(posedge clk) begin
        logic [`WB_DATA_W-1:0] result;
        result = expectedResult();
        if (!rst) begin
            checkValue("wbResult", result, wbResult);
            checkValue("wbPc", mPc, wbPc);
            checkValue("wbAluOut", mAluOut, wbAluOut);
            checkValue("wbDst", {{(`WB_DATA_W-`WB_REG_AW){1'b0}}, mDst},
                       {{(`WB_DATA_W-`WB_REG_AW){1'b0}}, wbDst});
            checkValue("wbStoreReq", {{(`WB_DATA_W-1){1'b0}}, mStoreReq},
                       {{(`WB_DATA_W-1){1'b0}}, wbStoreReq});
            checkValue("rdDataA", expectedRead(rdAddrA), rdDataA);
            checkValue("rdDataB", expectedRead(rdAddrB), rdDataB);
            checkValue("hiData", mHi, hiData);
            checkValue("loData", mLo, loData);
        end
        if (rst) begin
            for (int i = 0; i < `WB_REG_NUM; i++) begin
                mGpr[i[`WB_REG_AW-1:0]] = '0;
            end
            mHi = '0;
            mLo = '0;
        end else begin
            if (mGprWr && !wbDisWr && mDst != '0) begin
                mGpr[mDst] = result;  // the held item writes while not suppressed.
            end
            if (mHiWr && !wbDisWr) begin
                mHi = mOutB;
            end
            if (mLoWr && !wbDisWr) begin
                mLo = mOutB;
            end
        end
        if (rst || wbFlush) begin
            {mAluOut, mPc, mOutB, mDmOut, mDst} = '0;
            mSel = WB_SEL_LINK;
            {mGprWr, mHiWr, mLoWr, mStoreReq} = '0;
        end else if (wbWr) begin
            {mAluOut, mPc, mOutB, mDmOut} = {mem2AluOut, mem2Pc, mem2OutB, mem2DmOut};
            mSel = mem2WbSel;
            mDst = mem2Dst;
            {mGprWr, mHiWr, mLoWr, mStoreReq} = {mem2GprWr, mem2HiWr, mem2LoWr, mem2StoreReq};
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > CycleLimit) begin
            $display("Timeout: the run did not end within %0d cycles.", CycleLimit);
            $display("Finished with errors");
            $fatal(1);
        end
    end

    task automatic driveItem(input WbSelType sel, input logic [`WB_REG_AW-1:0] dst,
                             input logic gprWr, input logic hiWr, input logic loWr,
                             input logic storeReq);
        mem2AluOut   = randWord();
        mem2Pc       = randWord();
        mem2Instr    = randWord();
        mem2OutB     = randWord();
        mem2DmOut    = randWord();
        mem2WbSel    = sel;
        mem2Dst      = dst;
        {mem2GprWr, mem2HiWr, mem2LoWr, mem2StoreReq} = {gprWr, hiWr, loWr, storeReq};
    endtask

    // sets the controls for one cycle and steps to the next falling edge.
    task automatic runCycle(input logic wr, input logic flush, input logic disWr);
        logic [`WB_DATA_W-1:0] r;
        r       = randWord();
        wbWr    = wr;
        wbFlush = flush;
        wbDisWr = disWr;
        rdAddrA = savedDst;         // reads back the register written one edge earlier.
        rdAddrB = r[`WB_REG_AW-1:0];
        savedDst = mDst;
        @(negedge clk);
    endtask

    initial begin
        logic [`WB_DATA_W-1:0] r;
        rst = 1'b1;
        {wbFlush, wbWr, wbDisWr} = '0;
        driveItem(WB_SEL_LINK, '0, 1'b0, 1'b0, 1'b0, 1'b0);
        rdAddrA = '0;
        rdAddrB = '0;
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        testName = "result select";
        for (int k = 0; k < SelectCycles; k++) begin
            r = randWord();
            driveItem(WbSelType'(k % 4), r[`WB_REG_AW-1:0], 1'b1, 1'b0, 1'b0, r[8]);
            runCycle(1'b1, 1'b0, 1'b0);
        end

        testName = "gpr write";
        for (int k = 0; k < GprCycles; k++) begin
            r = randWord();
            // every fourth item aims at register 0, which must stay zero.
            driveItem(WbSelType'(r[9:8]), (k % 4 == 0) ? '0 : r[`WB_REG_AW-1:0],
                      1'b1, 1'b0, 1'b0, 1'b0);
            runCycle(1'b1, 1'b0, 1'b0);
        end

        testName = "hi lo write";
        for (int k = 0; k < HiLoCycles; k++) begin
            driveItem(WB_SEL_OPB, '0, 1'b0, (k % 3) != 1, (k % 3) != 0, 1'b0);
            runCycle(1'b1, 1'b0, 1'b0);
        end

        testName = "stall hold";
        repeat (2) begin
            driveItem(WB_SEL_MEM, 5'd9, 1'b1, 1'b1, 1'b0, 1'b1);
            runCycle(1'b1, 1'b0, 1'b0);
            repeat (5) begin
                driveItem(WB_SEL_ALU, 5'd12, 1'b1, 1'b0, 1'b1, 1'b0);
                runCycle(1'b0, 1'b0, 1'b0);
            end
        end

        testName = "flush";
        driveItem(WB_SEL_OPB, 5'd7, 1'b1, 1'b1, 1'b1, 1'b1);
        runCycle(1'b1, 1'b0, 1'b0);
        driveItem(WB_SEL_ALU, 5'd3, 1'b1, 1'b1, 1'b1, 1'b1);
        runCycle(1'b1, 1'b1, 1'b0);  // flush beats the write enable.
        runCycle(1'b0, 1'b0, 1'b0);
        runCycle(1'b0, 1'b0, 1'b0);

        testName = "write suppression";
        repeat (2) begin
            driveItem(WB_SEL_MEM, 5'd21, 1'b1, 1'b1, 1'b1, 1'b0);
            runCycle(1'b1, 1'b0, 1'b1);
            repeat (3) runCycle(1'b0, 1'b0, 1'b1);
            repeat (2) runCycle(1'b0, 1'b0, 1'b0);
        end

        testName = "random";
        for (int k = 0; k < RandomCycles; k++) begin
            r = randWord();
            driveItem(WbSelType'(r[9:8]), r[14:10], r[15], r[16], r[17], r[18]);
            r = randWord();
            runCycle(r[0] | r[1], r[4:2] == 3'd0, r[7:5] == 3'd0);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+source
source/wbPkg.sv
source/wbStage.sv
source/archState.sv
source/writebackTop.sv
dv/writebackTb.sv

/* Makefile */
# Verilator build and run for the writeback stage.

TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
TOP      = writebackTb
FILELIST = src.f
OBJDIR   = obj_dir
LOG      = sim.log
PASSMSG  = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASSMSG)" $(LOG); then \
		echo "Simulation passed."; \
	else \
		echo "Simulation failed."; \
		exit 1; \
	fi

lint:
	$(TOOL) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)
